// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int data_w = 32;

    typedef logic [data_w-1:0] word_t;

    // encoded op, one value per instruction class
    typedef enum logic [4:0] {
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_nor,
        op_xor,
        op_lui,
        op_sll,
        op_srl,
        op_sra,
        op_mult,
        op_multu,
        op_div,
        op_divu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo,
        op_nop
    } alu_op_e;

endpackage

`default_nettype wire

// File: verilog/md_pkg.sv
`default_nettype none

package md_pkg;

    // one quotient bit per step
    localparam int div_steps = exec_pkg::data_w;

    typedef struct packed {
        exec_pkg::word_t rem;  // goes to HI
        exec_pkg::word_t quo;  // goes to LO
    } div_res_t;

    // same 64 bits, read as product or as rem/quo pair
    typedef union packed {
        logic [2*exec_pkg::data_w-1:0] product;
        div_res_t                      divres;
    } md_result_u;

endpackage

`default_nettype wire

// File: verilog/md_if.sv
`default_nettype none

interface md_if;

    logic            start;      // one-cycle pulse, operands valid with it
    logic            is_signed;
    exec_pkg::word_t src1;
    exec_pkg::word_t src2;
    logic            done;       // one-cycle pulse, hi/lo valid with it
    exec_pkg::word_t hi;
    exec_pkg::word_t lo;

    modport ctrl (output start, is_signed, src1, src2, input done, hi, lo);
    modport unit (input start, is_signed, src1, src2, output done, hi, lo);

endinterface

`default_nettype wire

// File: verilog/alu_core.sv
`default_nettype none

module alu_core (
    input  exec_pkg::alu_op_e op,
    input  exec_pkg::word_t   src1,
    input  exec_pkg::word_t   src2,
    input  logic              issue,
    output exec_pkg::word_t   result,
    output logic              overflow
);

    localparam int w = exec_pkg::data_w;

    logic            sel_add;
    logic            sel_sr;
    logic            inv_b;
    logic            adder_cout;
    exec_pkg::word_t adder_b;
    exec_pkg::word_t adder_sum;
    exec_pkg::word_t slt_res;
    exec_pkg::word_t sltu_res;
    exec_pkg::word_t sll_res;
    exec_pkg::word_t sr_res;
    logic [2*w-1:0]  sr64;

    assign sel_add = (op == exec_pkg::op_add) || (op == exec_pkg::op_addu) ||
                     (op == exec_pkg::op_sub) || (op == exec_pkg::op_subu);
    assign sel_sr  = (op == exec_pkg::op_srl) || (op == exec_pkg::op_sra);
    assign inv_b   = (op == exec_pkg::op_sub) || (op == exec_pkg::op_subu) ||
                     (op == exec_pkg::op_slt) || (op == exec_pkg::op_sltu);

    // single adder, a + ~b + 1 for the subtracting ops
    assign adder_b = inv_b ? ~src2 : src2;
    assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + (w + 1)'(inv_b);

    // operand signs differ and the difference sign breaks the tie
    assign slt_res  = {{(w - 1){1'b0}},
                       (src1[w-1] & ~src2[w-1]) |
                       (~(src1[w-1] ^ src2[w-1]) & adder_sum[w-1])};
    assign sltu_res = {{(w - 1){1'b0}}, ~adder_cout};  // borrow out

    assign sll_res = src2 << src1[4:0];
    assign sr64    = {{w{(op == exec_pkg::op_sra) & src2[w-1]}}, src2} >> src1[4:0];
    assign sr_res  = sr64[w-1:0];

    // trap only for add/sub, the unsigned forms never flag
    assign overflow = issue &&
                      ((op == exec_pkg::op_add) || (op == exec_pkg::op_sub)) &&
                      (src1[w-1] == adder_b[w-1]) &&
                      (adder_sum[w-1] != src1[w-1]);

    assign result = ({w{sel_add}}                   & adder_sum)
                  | ({w{op == exec_pkg::op_slt}}    & slt_res)
                  | ({w{op == exec_pkg::op_sltu}}   & sltu_res)
                  | ({w{op == exec_pkg::op_and}}    & (src1 & src2))
                  | ({w{op == exec_pkg::op_or}}     & (src1 | src2))
                  | ({w{op == exec_pkg::op_nor}}    & ~(src1 | src2))
                  | ({w{op == exec_pkg::op_xor}}    & (src1 ^ src2))
                  | ({w{op == exec_pkg::op_lui}}    & {src2[15:0], 16'b0})
                  | ({w{op == exec_pkg::op_sll}}    & sll_res)
                  | ({w{sel_sr}}                    & sr_res);

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
`default_nettype none

module mul_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic clk,
    input  logic reset,
    md_if.unit   bus
);

    localparam int w      = exec_pkg::data_w;
    localparam int prod_w = 2 * w;

    if ((MUL_STAGES < 2) || (MUL_STAGES > 4)) begin : g_bad_stages
        $error("mul_unit: MUL_STAGES must be 2 to 4");
    end

    exec_pkg::word_t   mag_a;
    exec_pkg::word_t   mag_b;
    logic              neg;
    logic [prod_w-1:0] prod_q [MUL_STAGES];
    logic [MUL_STAGES-1:0] neg_q;
    logic [MUL_STAGES-1:0] vld_q;
    logic [prod_w-1:0] prod_out;

    // unsigned multiply on magnitudes, sign fixed at the end
    assign mag_a = (bus.is_signed && bus.src1[w-1]) ? -bus.src1 : bus.src1;
    assign mag_b = (bus.is_signed && bus.src2[w-1]) ? -bus.src2 : bus.src2;
    assign neg   = bus.is_signed && (bus.src1[w-1] ^ bus.src2[w-1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MUL_STAGES-2:0], bus.start};
        end
    end

    always_ff @(posedge clk) begin
        prod_q[0] <= prod_w'(mag_a) * prod_w'(mag_b);
        neg_q     <= {neg_q[MUL_STAGES-2:0], neg};
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign prod_out = neg_q[MUL_STAGES-1] ? -prod_q[MUL_STAGES-1] : prod_q[MUL_STAGES-1];

    assign bus.done = vld_q[MUL_STAGES-1];
    assign bus.hi   = prod_out[prod_w-1:w];
    assign bus.lo   = prod_out[w-1:0];

    // controller keeps a single multiply in the pipeline
    a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
        bus.start |-> (vld_q == '0));

endmodule

`default_nettype wire

// File: verilog/div_unit.sv
`default_nettype none

module div_unit (
    input  logic clk,
    input  logic reset,
    md_if.unit   bus
);

    localparam int w     = exec_pkg::data_w;
    localparam int cnt_w = $clog2(md_pkg::div_steps);

    logic            running_q;
    logic            finish_q;
    logic [cnt_w-1:0] step_q;
    logic            last_step;
    exec_pkg::word_t rem_q;      // partial remainder
    exec_pkg::word_t quo_q;      // dividend bits out, quotient bits in
    exec_pkg::word_t dsr_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    exec_pkg::word_t mag_a;
    exec_pkg::word_t mag_b;
    logic [w:0]      trial;
    logic            fits;

    assign mag_a = (bus.is_signed && bus.src1[w-1]) ? -bus.src1 : bus.src1;
    assign mag_b = (bus.is_signed && bus.src2[w-1]) ? -bus.src2 : bus.src2;

    // remainder stays below the divisor, so bit w of the trial is the borrow
    assign trial     = {rem_q, quo_q[w-1]} - {1'b0, dsr_q};
    assign fits      = ~trial[w];
    assign last_step = (step_q == cnt_w'(md_pkg::div_steps - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            running_q <= 1'b0;
            finish_q  <= 1'b0;
            step_q    <= '0;
        end else begin
            finish_q <= running_q && last_step;
            if (bus.start) begin
                running_q <= 1'b1;
                step_q    <= '0;
            end else if (running_q) begin
                step_q <= step_q + 1'b1;
                if (last_step) begin
                    running_q <= 1'b0;
                end
            end
        end
    end

    // divisor of zero never borrows, giving all-ones quotient and rem = dividend
    always_ff @(posedge clk) begin
        if (bus.start) begin
            rem_q     <= '0;
            quo_q     <= mag_a;
            dsr_q     <= mag_b;
            neg_quo_q <= bus.is_signed && (bus.src1[w-1] ^ bus.src2[w-1]);
            neg_rem_q <= bus.is_signed && bus.src1[w-1];  // follows dividend
        end else if (running_q) begin
            rem_q <= fits ? trial[w-1:0] : {rem_q[w-2:0], quo_q[w-1]};
            quo_q <= {quo_q[w-2:0], fits};
        end
    end

    assign bus.done = finish_q;
    assign bus.hi   = neg_rem_q ? -rem_q : rem_q;
    assign bus.lo   = neg_quo_q ? -quo_q : quo_q;

    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        bus.start |-> !running_q);

endmodule

`default_nettype wire

// File: verilog/hilo_ctrl.sv
`default_nettype none

module hilo_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  logic              cancel,
    input  exec_pkg::alu_op_e op,
    input  exec_pkg::word_t   src1,
    input  exec_pkg::word_t   src2,
    md_if.ctrl                mul_bus,
    md_if.ctrl                div_bus,
    output exec_pkg::word_t   hi,
    output exec_pkg::word_t   lo,
    output logic              busy
);

    localparam int w = exec_pkg::data_w;

    logic               is_mul;
    logic               is_div;
    logic               accept;
    logic               pend_q;
    logic               pend_div_q;    // which unit owns the pending op
    logic               mul_cancel_q;  // cancelled op still in the unit
    logic               div_cancel_q;
    logic               md_done;
    logic               md_write;
    md_pkg::md_result_u md_res;
    exec_pkg::word_t    md_hi;
    exec_pkg::word_t    md_lo;

    assign is_mul = (op == exec_pkg::op_mult) || (op == exec_pkg::op_multu);
    assign is_div = (op == exec_pkg::op_div) || (op == exec_pkg::op_divu);
    assign accept = issue && !pend_q;
    assign busy   = pend_q;

    // a unit still draining a cancelled op takes no new start
    assign mul_bus.start     = accept && is_mul && !mul_cancel_q;
    assign mul_bus.is_signed = (op == exec_pkg::op_mult);
    assign mul_bus.src1      = src1;
    assign mul_bus.src2      = src2;
    assign div_bus.start     = accept && is_div && !div_cancel_q;
    assign div_bus.is_signed = (op == exec_pkg::op_div);
    assign div_bus.src1      = src1;
    assign div_bus.src2      = src2;

    assign md_done  = pend_div_q ? div_bus.done : mul_bus.done;
    assign md_write = pend_q && md_done && !cancel;

    // divider fills the rem/quo view, multiplier the product view
    always_comb begin
        if (pend_div_q) begin
            md_res.divres.rem = div_bus.hi;
            md_res.divres.quo = div_bus.lo;
        end else begin
            md_res.product = {mul_bus.hi, mul_bus.lo};
        end
    end

    assign md_hi = md_res.product[2*w-1:w];  // rem for a divide
    assign md_lo = md_res.product[w-1:0];    // quo for a divide

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q       <= 1'b0;
            pend_div_q   <= 1'b0;
            mul_cancel_q <= 1'b0;
            div_cancel_q <= 1'b0;
            hi           <= '0;
            lo           <= '0;
        end else begin
            if (mul_bus.start || div_bus.start) begin
                pend_q     <= 1'b1;
                pend_div_q <= div_bus.start;
            end else if (pend_q && (md_done || cancel)) begin
                pend_q <= 1'b0;
            end
            if (mul_cancel_q && mul_bus.done) begin
                mul_cancel_q <= 1'b0;
            end
            if (div_cancel_q && div_bus.done) begin
                div_cancel_q <= 1'b0;
            end
            if (pend_q && cancel && !md_done) begin  // done pulse still to come
                if (pend_div_q) begin
                    div_cancel_q <= 1'b1;
                end else begin
                    mul_cancel_q <= 1'b1;
                end
            end
            if (md_write) begin
                hi <= md_hi;
                lo <= md_lo;
            end else if (accept && (op == exec_pkg::op_mthi)) begin
                hi <= src1;
            end else if (accept && (op == exec_pkg::op_mtlo)) begin
                lo <= src1;
            end
        end
    end

    // a HI/LO op issued while busy leaves the pair alone
    a_busy_drop: assert property (@(posedge clk) disable iff (reset)
        (issue && busy && !md_write &&
         (is_mul || is_div || (op == exec_pkg::op_mthi) || (op == exec_pkg::op_mtlo)))
        |=> ($stable(hi) && $stable(lo)));

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
`default_nettype none

module exec_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  exec_pkg::alu_op_e op,
    input  exec_pkg::word_t   src1,
    input  exec_pkg::word_t   src2,
    input  logic              cancel,
    output exec_pkg::word_t   result,
    output logic              overflow,
    output logic              busy
);

    exec_pkg::word_t alu_result;
    exec_pkg::word_t hi;
    exec_pkg::word_t lo;

    md_if mul_bus ();
    md_if div_bus ();

    alu_core alu_core_i (
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .issue    (issue),
        .result   (alu_result),
        .overflow (overflow)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) mul_unit_i (
        .clk   (clk),
        .reset (reset),
        .bus   (mul_bus)
    );

    div_unit div_unit_i (
        .clk   (clk),
        .reset (reset),
        .bus   (div_bus)
    );

    hilo_ctrl hilo_ctrl_i (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue),
        .cancel  (cancel),
        .op      (op),
        .src1    (src1),
        .src2    (src2),
        .mul_bus (mul_bus),
        .div_bus (div_bus),
        .hi      (hi),
        .lo      (lo),
        .busy    (busy)
    );

    // mfhi/mflo read straight from the HI/LO pair
    assign result = (op == exec_pkg::op_mfhi) ? hi :
                    (op == exec_pkg::op_mflo) ? lo : alu_result;

endmodule

`default_nettype wire

// File: sim/tb_exec_unit.sv
`default_nettype none

module tb_exec_unit;

    localparam int mul_stages     = 3;
    localparam int timeout_cycles = 100;

    logic              clk;
    logic              reset;
    logic              issue;
    exec_pkg::alu_op_e op;
    exec_pkg::word_t   src1;
    exec_pkg::word_t   src2;
    logic              cancel;
    exec_pkg::word_t   result;
    logic              overflow;
    logic              busy;
    logic [31:0]       seed;

    exec_unit #(
        .MUL_STAGES (mul_stages)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .cancel   (cancel),
        .result   (result),
        .overflow (overflow),
        .busy     (busy)
    );

    always #4 clk = ~clk;

    function automatic exec_pkg::word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic exec_pkg::word_t alu_model(exec_pkg::alu_op_e f, exec_pkg::word_t a,
                                                  exec_pkg::word_t b);
        case (f)
            exec_pkg::op_add, exec_pkg::op_addu: return a + b;
            exec_pkg::op_sub, exec_pkg::op_subu: return a - b;
            exec_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::op_sltu: return (a < b) ? 32'd1 : 32'd0;
            exec_pkg::op_and:  return a & b;
            exec_pkg::op_or:   return a | b;
            exec_pkg::op_nor:  return ~(a | b);
            exec_pkg::op_xor:  return a ^ b;
            exec_pkg::op_lui:  return {b[15:0], 16'h0000};
            exec_pkg::op_sll:  return b << a[4:0];  // amount from src1
            exec_pkg::op_srl:  return b >> a[4:0];
            exec_pkg::op_sra:  return $signed(b) >>> a[4:0];
            default:           return '0;
        endcase
    endfunction

    // 33-bit signed result, top two bits disagree on overflow
    function automatic logic ovf_model(exec_pkg::alu_op_e f, exec_pkg::word_t a,
                                       exec_pkg::word_t b);
        logic [32:0] wide;
        if (f == exec_pkg::op_add) wide = {a[31], a} + {b[31], b};
        else if (f == exec_pkg::op_sub) wide = {a[31], a} - {b[31], b};
        else return 1'b0;
        return wide[32] ^ wide[31];
    endfunction

    function automatic logic [63:0] mul_model(logic sgn, exec_pkg::word_t a, exec_pkg::word_t b);
        if (sgn) return {{32{a[31]}}, a} * {{32{b[31]}}, b};
        return {32'h0, a} * {32'h0, b};
    endfunction

    function automatic md_pkg::md_result_u div_model(logic sgn, exec_pkg::word_t a,
                                                     exec_pkg::word_t b);
        md_pkg::md_result_u r;
        exec_pkg::word_t    ma;
        exec_pkg::word_t    mb;
        exec_pkg::word_t    qm;
        exec_pkg::word_t    rm;
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        qm = (mb == 0) ? '1 : ma / mb;  // zero divisor gives all ones
        rm = (mb == 0) ? ma : ma % mb;
        r.divres.quo = (sgn && (a[31] ^ b[31])) ? -qm : qm;
        r.divres.rem = (sgn && a[31]) ? -rm : rm;  // sign of dividend
        return r;
    endfunction

    task automatic check_word(string name, exec_pkg::word_t got, exec_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic issue_op(exec_pkg::alu_op_e f, exec_pkg::word_t a, exec_pkg::word_t b);
        @(posedge clk);
        issue <= 1'b1;
        op    <= f;
        src1  <= a;
        src2  <= b;
        @(posedge clk);
        issue <= 1'b0;
        op    <= exec_pkg::op_nop;
    endtask

    // counts busy cycles seen at the falling edge
    task automatic wait_not_busy(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("busy did not fall within %0d cycles", timeout_cycles);
                $display("Simulation failed");
                $fatal(1, "wait timed out");
            end
            @(negedge clk);
        end
    endtask

    task automatic read_hilo(exec_pkg::word_t exp_hi, exec_pkg::word_t exp_lo);
        @(posedge clk);
        op <= exec_pkg::op_mfhi;
        @(negedge clk);
        check_word("hi", result, exp_hi);
        @(posedge clk);
        op <= exec_pkg::op_mflo;
        @(negedge clk);
        check_word("lo", result, exp_lo);
    endtask

    task automatic check_int(exec_pkg::alu_op_e f, exec_pkg::word_t a, exec_pkg::word_t b,
                             logic iss);
        @(posedge clk);
        issue <= iss;
        op    <= f;
        src1  <= a;
        src2  <= b;
        @(negedge clk);
        check_word("result", result, alu_model(f, a, b));
        check_flag("overflow", overflow, iss && ovf_model(f, a, b));
    endtask

    task automatic run_all_ops(exec_pkg::word_t a, exec_pkg::word_t b);
        for (int k = 0; k <= int'(exec_pkg::op_sra); k++) begin
            check_int(exec_pkg::alu_op_e'(k), a, b, 1'b1);
        end
    endtask

    task automatic test_integer_ops();
        exec_pkg::word_t a;
        run_all_ops(32'h0000_001f, 32'h8000_0001);  // largest shift amount
        run_all_ops(32'h1234_5678, 32'h1234_5678);  // equal operands
        run_all_ops(32'h7fff_ffff, 32'h8000_0000);
        run_all_ops(32'h8000_0000, 32'h7fff_ffff);
        run_all_ops(32'hffff_ffff, 32'h0000_0000);
        for (int i = 0; i < 30; i++) begin
            a = next_rand();
            run_all_ops(a, next_rand());
        end
    endtask

    task automatic test_overflow();
        exec_pkg::word_t a;
        check_int(exec_pkg::op_add, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
        check_int(exec_pkg::op_addu, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
        check_int(exec_pkg::op_sub, 32'h8000_0000, 32'h0000_0001, 1'b1);
        check_int(exec_pkg::op_subu, 32'h8000_0000, 32'h0000_0001, 1'b1);
        check_int(exec_pkg::op_add, 32'h8000_0000, 32'h8000_0000, 1'b0);  // no trap without issue
        for (int i = 0; i < 40; i++) begin
            a = next_rand();
            check_int(i[0] ? exec_pkg::op_sub : exec_pkg::op_add, a, next_rand(), 1'b1);
        end
        @(posedge clk);
        issue <= 1'b0;
        op    <= exec_pkg::op_nop;
    endtask

    task automatic test_multiply();
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        logic [63:0]     p;
        int              cycles;
        for (int i = 0; i < 10; i++) begin
            a = (i == 0) ? 32'h8000_0000 : next_rand();
            b = (i == 0) ? 32'h8000_0000 : next_rand();
            p = mul_model(i[0], a, b);
            issue_op(i[0] ? exec_pkg::op_mult : exec_pkg::op_multu, a, b);
            wait_not_busy(cycles);
            check_word("busy cycles", exec_pkg::word_t'(cycles), exec_pkg::word_t'(mul_stages));
            read_hilo(p[63:32], p[31:0]);
        end
    endtask

    task automatic test_divide();
        exec_pkg::word_t    a;
        exec_pkg::word_t    b;
        md_pkg::md_result_u r;
        int                 cycles;
        for (int i = 0; i < 12; i++) begin
            a = next_rand();
            b = (i < 2) ? 32'h0 : (i[3] ? (next_rand() >> 20) : next_rand());
            if (i == 2) begin
                a = 32'h8000_0000;  // signed minimum over minus one
                b = 32'hffff_ffff;
            end
            r = div_model(!i[0], a, b);
            issue_op(i[0] ? exec_pkg::op_divu : exec_pkg::op_div, a, b);
            wait_not_busy(cycles);
            read_hilo(r.divres.rem, r.divres.quo);
        end
    endtask

    task automatic test_moves();
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        logic [63:0]     p;
        int              cycles;
        a = next_rand();
        b = next_rand();
        issue_op(exec_pkg::op_mthi, a, 32'h0);
        issue_op(exec_pkg::op_mtlo, b, 32'h0);
        read_hilo(a, b);
        p = mul_model(1'b1, a, b);
        @(posedge clk);
        issue <= 1'b1;
        op    <= exec_pkg::op_mult;
        src1  <= a;
        src2  <= b;
        @(posedge clk);
        op    <= exec_pkg::op_multu;  // second multiply lands while busy
        src1  <= next_rand();
        src2  <= next_rand();
        @(posedge clk);
        issue <= 1'b0;
        op    <= exec_pkg::op_nop;
        wait_not_busy(cycles);
        read_hilo(p[63:32], p[31:0]);
    endtask

    task automatic cancel_pending();
        @(posedge clk);
        cancel <= 1'b1;
        @(negedge clk);
        check_flag("busy", busy, 1'b1);
        @(posedge clk);
        cancel <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic test_cancel();
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        int              cycles;
        a = next_rand();
        b = next_rand();
        issue_op(exec_pkg::op_mthi, a, 32'h0);
        issue_op(exec_pkg::op_mtlo, b, 32'h0);
        issue_op(exec_pkg::op_div, next_rand(), next_rand());
        repeat (5) @(posedge clk);
        cancel_pending();
        read_hilo(a, b);
        issue_op(exec_pkg::op_mult, next_rand(), next_rand());
        cancel_pending();
        repeat (40) @(posedge clk);  // both units drain, late done pulses
        read_hilo(a, b);
        issue_op(exec_pkg::op_divu, 32'd100, 32'd7);
        wait_not_busy(cycles);
        read_hilo(32'd2, 32'd14);
    endtask

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        issue  = 1'b0;
        op     = exec_pkg::op_nop;
        src1   = '0;
        src2   = '0;
        cancel = 1'b0;
        seed   = 32'hf6b1_c7c7;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        read_hilo('0, '0);
        test_integer_ops();
        test_overflow();
        test_multiply();
        test_divide();
        test_moves();
        test_cancel();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
verilog/exec_pkg.sv
verilog/md_pkg.sv
verilog/md_if.sv
verilog/alu_core.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/hilo_ctrl.sv
verilog/exec_unit.sv
sim/tb_exec_unit.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - verilog/exec_pkg.sv
  - verilog/md_pkg.sv
  - verilog/md_if.sv
  - verilog/alu_core.sv
  - verilog/mul_unit.sv
  - verilog/div_unit.sv
  - verilog/hilo_ctrl.sv
  - verilog/exec_unit.sv
  - target: simulation
    files:
      - sim/tb_exec_unit.sv
